// File: src/gat_cfg.svh
`ifndef GAT_CFG_SVH
`define GAT_CFG_SVH

// ----------------------------------------
// datapath sizing
// ----------------------------------------
`define GAT_NUM_LANES    8
`define GAT_DATA_W       12
`define GAT_COL_W        6
`define GAT_NODE_W       14
`define GAT_FEAT_ADDR_W  16
`define GAT_SCORE_W      24
`define GAT_WGT_W        16
`define GAT_DENOM_W      20
`define GAT_SUM_W        32
`define GAT_SCORE_SHIFT  4

// ----------------------------------------
// debug watch points
// ----------------------------------------
`define GAT_WATCH_ADDR_A 10
`define GAT_WATCH_ADDR_B 20
`define GAT_WATCH_LANE   2
`define GAT_FEAT_LIMIT   43328

`endif

// File: src/gat_data_pkg.sv
`include "gat_cfg.svh"

package gat_data_pkg;

  typedef logic [`GAT_DATA_W-1:0] lane_t;
  typedef logic [`GAT_NODE_W-1:0] node_idx_t;

  // one sparse feature entry
  typedef struct packed {
    lane_t                 value;
    logic [`GAT_COL_W-1:0] col;
    logic                  last_nz; // final nonzero of the node
  } nonzero_t;

  typedef lane_t [`GAT_NUM_LANES-1:0] wh_vec_t;

  typedef struct packed {
    node_idx_t idx;
    logic      batch_last;
    wh_vec_t   wh;
  } node_rec_t;

  typedef struct packed {
    node_rec_t             rec;
    logic [`GAT_WGT_W-1:0] weight; // power of two
  } weighted_rec_t;

  typedef struct packed {
    logic                        ena;
    logic [`GAT_FEAT_ADDR_W-1:0] addr;
    logic [`GAT_SUM_W-1:0]       data;
  } feat_wr_t;

  typedef enum logic [1:0] {IDLE, RUN, HOLD} stage_state_e;

endpackage

// File: src/gat_dbg_pkg.sv
package gat_dbg_pkg;

  // one bit per stage strobe, spmm_vld in the msb
  typedef struct packed {
    logic spmm_vld;
    logic spmm_rdy;
    logic dmvm_vld;
    logic dmvm_rdy;
    logic sm_vld;
    logic sm_rdy;
    logic aggr_vld;
    logic aggr_rdy;
  } stage_flags_t;

  typedef logic [31:0] dbg_word_t;

  // word_0 flags/range/count, word_1 and word_2 watch captures
  typedef struct packed {
    dbg_word_t word_2;
    dbg_word_t word_1;
    dbg_word_t word_0;
  } debug_words_t;

endpackage

// File: src/spmm_engine.sv
`timescale 1ns/1ps
`include "gat_cfg.svh"

module spmm_engine (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      nz_vld_i,
  input  gat_data_pkg::nonzero_t    nz_i,
  input  gat_data_pkg::node_idx_t   node_idx_i,
  input  logic                      batch_last_i,
  input  logic                      wgt_we_i,
  input  logic [`GAT_COL_W-1:0]     wgt_col_i,
  input  gat_data_pkg::wh_vec_t     wgt_row_i,
  input  logic                      dmvm_rdy_i,
  output logic                      spmm_vld_o,
  output logic                      spmm_rdy_o,
  output gat_data_pkg::node_rec_t   rec_o,
  output gat_data_pkg::wh_vec_t     sppe_o
);
  import gat_data_pkg::*;

  localparam int NUM_COLS = 1 << `GAT_COL_W;

  wh_vec_t      wgt_mem [NUM_COLS];
  wh_vec_t      wgt_row;
  wh_vec_t      acc_q;
  node_idx_t    idx_q;
  logic         last_q;
  stage_state_e state_q;

  // ----------------------------------------
  // weight memory
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (wgt_we_i) begin
      wgt_mem[wgt_col_i] <= wgt_row_i; // whole lane row per write
    end
  end

  assign wgt_row = wgt_mem[nz_i.col];

  assign spmm_rdy_o = (state_q != HOLD);
  assign spmm_vld_o = (state_q == HOLD) && dmvm_rdy_i;
  assign rec_o      = '{idx: idx_q, batch_last: last_q, wh: acc_q};
  assign sppe_o     = acc_q;

  // ----------------------------------------
  // lane accumulators and FSM
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      acc_q   <= '0;
    end else begin
      case (state_q)
        IDLE, RUN: begin
          if (nz_vld_i) begin
            for (int l = 0; l < `GAT_NUM_LANES; l++) begin
              acc_q[l] <= acc_q[l] + lane_t'(nz_i.value * wgt_row[l]); // wraps
            end
            state_q <= nz_i.last_nz ? HOLD : RUN;
          end
        end
        HOLD: begin
          if (dmvm_rdy_i) begin
            acc_q   <= '0; // record leaves this cycle
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // node tag, taken with the first nonzero
  always_ff @(posedge clk) begin
    if (state_q == IDLE && nz_vld_i) begin
      idx_q  <= node_idx_i;
      last_q <= batch_last_i;
    end
  end

endmodule

// File: src/dmvm_engine.sv
`timescale 1ns/1ps
`include "gat_cfg.svh"

module dmvm_engine (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           spmm_vld_i,
  input  gat_data_pkg::node_rec_t        rec_i,
  input  gat_data_pkg::wh_vec_t          attn_i,
  output logic                           dmvm_vld_o,
  output logic                           dmvm_rdy_o,
  output gat_data_pkg::node_rec_t        rec_o,
  output logic signed [`GAT_SCORE_W-1:0] score_o
);
  import gat_data_pkg::*;

  localparam int CNT_W     = $clog2(`GAT_NUM_LANES);
  localparam int LAST_LANE = `GAT_NUM_LANES - 1;

  stage_state_e                   state_q;
  node_rec_t                      rec_q;
  logic [CNT_W-1:0]               lane_q;
  logic signed [`GAT_SCORE_W-1:0] acc_q;
  logic signed [`GAT_SCORE_W-1:0] prod;

  assign prod = $signed(rec_q.wh[lane_q]) * $signed(attn_i[lane_q]);

  assign dmvm_vld_o = (state_q == HOLD); // one cycle after the last lane
  assign dmvm_rdy_o = (state_q == IDLE);
  assign rec_o      = rec_q;
  assign score_o    = acc_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      lane_q  <= '0;
      acc_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (spmm_vld_i) begin
            lane_q  <= '0;
            acc_q   <= '0;
            state_q <= RUN;
          end
        end
        RUN: begin
          acc_q  <= acc_q + prod; // one lane per cycle
          lane_q <= lane_q + 1'b1;
          if (lane_q == CNT_W'(LAST_LANE)) begin
            state_q <= HOLD;
          end
        end
        default: state_q <= IDLE; // HOLD is the pulse cycle
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && spmm_vld_i) begin
      rec_q <= rec_i;
    end
  end

endmodule

// File: src/softmax_unit.sv
`timescale 1ns/1ps
`include "gat_cfg.svh"

module softmax_unit (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           dmvm_vld_i,
  input  gat_data_pkg::node_rec_t        rec_i,
  input  logic signed [`GAT_SCORE_W-1:0] score_i,
  output logic                           sm_vld_o,
  output logic                           sm_rdy_o,
  output gat_data_pkg::weighted_rec_t    rec_o,
  output logic [`GAT_DENOM_W-1:0]        denom_o
);
  import gat_data_pkg::*;

  localparam int EXP_W   = $clog2(`GAT_WGT_W);
  localparam int EXP_MAX = `GAT_WGT_W - 1;

  logic signed [`GAT_SCORE_W-1:0] shifted;
  logic [EXP_W-1:0]               exp_val;
  logic [`GAT_WGT_W-1:0]          weight;
  weighted_rec_t                  rec_q;
  logic                           vld_q;
  logic [`GAT_DENOM_W-1:0]        denom_q;

  // exponent clipped to 0..15
  always_comb begin
    shifted = score_i >>> `GAT_SCORE_SHIFT;
    if (shifted < 0) begin
      exp_val = '0;
    end else if (shifted > EXP_MAX) begin
      exp_val = EXP_W'(EXP_MAX);
    end else begin
      exp_val = shifted[EXP_W-1:0];
    end
  end

  assign weight = 1 << exp_val;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q   <= 1'b0;
      denom_q <= '0;
    end else begin
      vld_q <= dmvm_vld_i;
      if (vld_q && rec_q.rec.batch_last) begin
        denom_q <= '0; // aggregator took the batch total
      end else if (dmvm_vld_i) begin
        denom_q <= denom_q + weight;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dmvm_vld_i) begin
      rec_q <= '{rec: rec_i, weight: weight};
    end
  end

  assign sm_vld_o = vld_q;
  assign sm_rdy_o = !vld_q;
  assign rec_o    = rec_q;
  assign denom_o  = denom_q;

endmodule

// File: src/aggr_engine.sv
`timescale 1ns/1ps
`include "gat_cfg.svh"

module aggr_engine (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         sm_vld_i,
  input  gat_data_pkg::weighted_rec_t  rec_i,
  input  logic [`GAT_DENOM_W-1:0]      denom_i,
  input  logic [`GAT_FEAT_ADDR_W-1:0]  feat_base_i,
  output logic                         aggr_vld_o,
  output logic                         aggr_rdy_o,
  output gat_data_pkg::feat_wr_t       feat_wr_o
);

  localparam int N     = `GAT_NUM_LANES;
  localparam int CNT_W = $clog2(N + 1);

  logic [N-1:0][`GAT_SUM_W-1:0] sum_q;
  logic [N-1:0][`GAT_SUM_W-1:0] prod;
  logic signed [`GAT_WGT_W:0]   w_s;
  logic [`GAT_DENOM_W-1:0]      denom_q;
  logic [CNT_W-1:0]             wr_cnt_q;
  logic                         busy_q;
  logic                         vld_q;
  logic                         last_wr;

  assign w_s     = {1'b0, rec_i.weight};
  assign last_wr = busy_q && (wr_cnt_q == CNT_W'(N));

  always_comb begin
    for (int l = 0; l < N; l++) begin
      prod[l] = w_s * $signed(rec_i.rec.wh[l]); // sign extended to 32
    end
  end

  // ----------------------------------------
  // lane sums and write-out sequencing
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_q    <= '0;
      wr_cnt_q <= '0;
      busy_q   <= 1'b0;
      vld_q    <= 1'b0;
    end else begin
      vld_q <= last_wr;
      if (sm_vld_i) begin
        for (int l = 0; l < N; l++) begin
          sum_q[l] <= sum_q[l] + prod[l];
        end
        if (rec_i.rec.batch_last) begin
          busy_q   <= 1'b1;
          wr_cnt_q <= '0;
        end
      end else if (busy_q) begin
        wr_cnt_q <= wr_cnt_q + 1'b1;
        if (last_wr) begin
          busy_q <= 1'b0;
          sum_q  <= '0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sm_vld_i && rec_i.rec.batch_last) begin
      denom_q <= denom_i; // includes the last node
    end
  end

  always_comb begin
    feat_wr_o.ena  = busy_q;
    feat_wr_o.addr = feat_base_i + wr_cnt_q;
    if (wr_cnt_q == CNT_W'(N)) begin
      feat_wr_o.data = `GAT_SUM_W'(denom_q);
    end else begin
      feat_wr_o.data = sum_q[wr_cnt_q];
    end
  end

  assign aggr_vld_o = vld_q;
  assign aggr_rdy_o = !busy_q;

endmodule

// File: src/debug_monitor.sv
`timescale 1ns/1ps
`include "gat_cfg.svh"

module debug_monitor (
  input  logic                        clk,
  input  logic                        rst_n,
  input  gat_dbg_pkg::stage_flags_t   flags_i,
  input  gat_data_pkg::node_idx_t     wh_addr_i,
  input  logic                        spmm_vld_i,
  input  gat_data_pkg::wh_vec_t       sppe_i,
  input  gat_data_pkg::feat_wr_t      feat_wr_i,
  output gat_dbg_pkg::debug_words_t   debug_o
);
  import gat_dbg_pkg::*;

  stage_flags_t           flags_q;
  logic                   range_q;
  logic                   range_hit;
  logic [15:0]            sm_cnt_q;
  logic [`GAT_DATA_W-1:0] cap_a_q;
  logic [`GAT_DATA_W-1:0] cap_b_q;

  assign range_hit = feat_wr_i.ena && (feat_wr_i.addr >= `GAT_FEAT_LIMIT);

  // ----------------------------------------
  // sticky flags, count, watch capture
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q  <= '0;
      range_q  <= 1'b0;
      sm_cnt_q <= '0;
      cap_a_q  <= '0;
      cap_b_q  <= '0;
    end else begin
      flags_q <= flags_q | flags_i; // cleared by reset only
      range_q <= range_q | range_hit;
      if (flags_i.sm_vld) begin
        sm_cnt_q <= sm_cnt_q + 1'b1;
      end
      if (spmm_vld_i && wh_addr_i == `GAT_WATCH_ADDR_A) begin
        cap_a_q <= sppe_i[`GAT_WATCH_LANE];
      end
      if (spmm_vld_i && wh_addr_i == `GAT_WATCH_ADDR_B) begin
        cap_b_q <= sppe_i[`GAT_WATCH_LANE];
      end
    end
  end

  assign debug_o.word_0 = {sm_cnt_q, 7'd0, range_q, flags_q};
  assign debug_o.word_1 = 32'(cap_a_q);
  assign debug_o.word_2 = 32'(cap_b_q);

endmodule

// File: src/gat_layer_top.sv
`timescale 1ns/1ps
`include "gat_cfg.svh"

module gat_layer_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        nz_vld_i,
  input  gat_data_pkg::nonzero_t      nz_i,
  input  gat_data_pkg::node_idx_t     node_idx_i,
  input  logic                        batch_last_i,
  input  logic                        wgt_we_i,
  input  logic [`GAT_COL_W-1:0]       wgt_col_i,
  input  gat_data_pkg::wh_vec_t       wgt_row_i,
  input  gat_data_pkg::wh_vec_t       attn_i,
  input  logic [`GAT_FEAT_ADDR_W-1:0] feat_base_i,
  output logic                        spmm_rdy_o,
  output logic                        aggr_vld_o,
  output gat_data_pkg::feat_wr_t      feat_wr_o,
  output gat_dbg_pkg::debug_words_t   debug_o
);
  import gat_data_pkg::*;
  import gat_dbg_pkg::*;

  node_rec_t                      spmm_rec;
  node_rec_t                      dmvm_rec;
  weighted_rec_t                  sm_rec;
  wh_vec_t                        sppe;
  logic signed [`GAT_SCORE_W-1:0] score;
  logic [`GAT_DENOM_W-1:0]        denom;
  logic                           spmm_vld;
  logic                           dmvm_vld;
  logic                           dmvm_rdy;
  logic                           sm_vld;
  logic                           sm_rdy;
  logic                           aggr_rdy;
  stage_flags_t                   flags;

  assign flags = '{spmm_vld: spmm_vld, spmm_rdy: spmm_rdy_o,
                   dmvm_vld: dmvm_vld, dmvm_rdy: dmvm_rdy,
                   sm_vld:   sm_vld,   sm_rdy:   sm_rdy,
                   aggr_vld: aggr_vld_o, aggr_rdy: aggr_rdy};

  spmm_engine spmm_engine_inst (
    .clk, .rst_n, .nz_vld_i, .nz_i, .node_idx_i, .batch_last_i,
    .wgt_we_i, .wgt_col_i, .wgt_row_i,
    .dmvm_rdy_i (dmvm_rdy),
    .spmm_vld_o (spmm_vld),
    .spmm_rdy_o (spmm_rdy_o),
    .rec_o      (spmm_rec),
    .sppe_o     (sppe)
  );

  dmvm_engine dmvm_engine_inst (
    .clk, .rst_n, .attn_i,
    .spmm_vld_i (spmm_vld),
    .rec_i      (spmm_rec),
    .dmvm_vld_o (dmvm_vld),
    .dmvm_rdy_o (dmvm_rdy),
    .rec_o      (dmvm_rec),
    .score_o    (score)
  );

  softmax_unit softmax_unit_inst (
    .clk, .rst_n,
    .dmvm_vld_i (dmvm_vld),
    .rec_i      (dmvm_rec),
    .score_i    (score),
    .sm_vld_o   (sm_vld),
    .sm_rdy_o   (sm_rdy),
    .rec_o      (sm_rec),
    .denom_o    (denom)
  );

  aggr_engine aggr_engine_inst (
    .clk, .rst_n, .feat_base_i,
    .sm_vld_i   (sm_vld),
    .rec_i      (sm_rec),
    .denom_i    (denom),
    .aggr_vld_o (aggr_vld_o),
    .aggr_rdy_o (aggr_rdy),
    .feat_wr_o  (feat_wr_o)
  );

  debug_monitor debug_monitor_inst (
    .clk, .rst_n,
    .flags_i    (flags),
    .wh_addr_i  (spmm_rec.idx), // wh address is the node index
    .spmm_vld_i (spmm_vld),
    .sppe_i     (sppe),
    .feat_wr_i  (feat_wr_o),
    .debug_o    (debug_o)
  );

endmodule

// File: verif/gat_layer_asserts.sv
`timescale 1ns/1ps
`include "gat_cfg.svh"

module gat_layer_asserts (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        nz_vld_i,
  input  gat_data_pkg::nonzero_t                      nz_i,
  input  logic                                        spmm_rdy_i,
  input  logic                                        spmm_vld_i,
  input  gat_data_pkg::node_idx_t                     wh_addr_i,
  input  logic                                        aggr_vld_i,
  input  gat_data_pkg::feat_wr_t                      feat_wr_i,
  input  gat_dbg_pkg::debug_words_t                   debug_i,
  input  logic [`GAT_NUM_LANES-1:0][`GAT_SUM_W-1:0]   exp_sum_i,
  input  logic [`GAT_DENOM_W-1:0]                     exp_denom_i,
  input  logic [`GAT_FEAT_ADDR_W-1:0]                 exp_base_i,
  input  gat_data_pkg::lane_t                         exp_cap_a_i,
  input  gat_data_pkg::lane_t                         exp_cap_b_i
);
  import gat_data_pkg::*;

  localparam int N = `GAT_NUM_LANES;

  int unsigned fail_cnt;
  logic [7:0]  wr_idx;
  logic        hit_a;
  logic        hit_b;

  assign hit_a = spmm_vld_i && (wh_addr_i == `GAT_WATCH_ADDR_A);
  assign hit_b = spmm_vld_i && (wh_addr_i == `GAT_WATCH_ADDR_B);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_idx <= '0;
    end else if (aggr_vld_i) begin
      wr_idx <= '0;
    end else if (feat_wr_i.ena) begin
      wr_idx <= wr_idx + 1'b1; // position within the write burst
    end
  end

  // ----------------------------------------
  // feature write-out
  // ----------------------------------------
  a_wr_addr: assert property (@(posedge clk) disable iff (!rst_n)
    feat_wr_i.ena |-> feat_wr_i.addr == exp_base_i + `GAT_FEAT_ADDR_W'(wr_idx))
    else begin
      $error("[FAIL] %0t feat_wr_o.addr expected %0h got %0h", $time,
             $sampled(exp_base_i + `GAT_FEAT_ADDR_W'(wr_idx)), $sampled(feat_wr_i.addr));
      fail_cnt++;
    end

  a_wr_data: assert property (@(posedge clk) disable iff (!rst_n)
    feat_wr_i.ena && wr_idx < N |-> feat_wr_i.data == exp_sum_i[wr_idx])
    else begin
      $error("[FAIL] %0t feat_wr_o.data expected %0h got %0h", $time,
             $sampled(exp_sum_i[wr_idx]), $sampled(feat_wr_i.data));
      fail_cnt++;
    end

  a_wr_denom: assert property (@(posedge clk) disable iff (!rst_n)
    feat_wr_i.ena && wr_idx == N |-> feat_wr_i.data == `GAT_SUM_W'(exp_denom_i))
    else begin
      $error("[FAIL] %0t feat_wr_o.data (denominator) expected %0h got %0h", $time,
             $sampled(exp_denom_i), $sampled(feat_wr_i.data));
      fail_cnt++;
    end

  a_wr_burst: assert property (@(posedge clk) disable iff (!rst_n)
    feat_wr_i.ena && wr_idx < N |=> feat_wr_i.ena)
    else begin
      $error("write burst stopped before the denominator write");
      fail_cnt++;
    end

  a_vld_after: assert property (@(posedge clk) disable iff (!rst_n)
    feat_wr_i.ena && wr_idx == N |=> aggr_vld_i && !feat_wr_i.ena)
    else begin
      $error("aggr_vld_o did not follow the last write, or extra writes came");
      fail_cnt++;
    end

  a_vld_once: assert property (@(posedge clk) disable iff (!rst_n)
    aggr_vld_i |-> wr_idx == N + 1)
    else begin
      $error("aggr_vld_o pulsed without a full write burst before it");
      fail_cnt++;
    end

  // ----------------------------------------
  // spmm ready level
  // ----------------------------------------
  a_rdy_reset: assert property (@(posedge clk) $rose(rst_n) |-> spmm_rdy_i)
    else begin
      $error("spmm_rdy_o was low right after reset");
      fail_cnt++;
    end

  a_rdy_low: assert property (@(posedge clk) disable iff (!rst_n)
    nz_vld_i && nz_i.last_nz |=> !spmm_rdy_i)
    else begin
      $error("spmm_rdy_o stayed high after the last nonzero of a node");
      fail_cnt++;
    end

  a_rdy_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !spmm_rdy_i && !spmm_vld_i |=> !spmm_rdy_i)
    else begin
      $error("spmm_rdy_o rose before the spmm valid pulse");
      fail_cnt++;
    end

  // ----------------------------------------
  // watch-address capture
  // ----------------------------------------
  a_cap_a: assert property (@(posedge clk) disable iff (!rst_n)
    hit_a |=> debug_i.word_1 == 32'(exp_cap_a_i))
    else begin
      $error("[FAIL] %0t debug_o.word_1 expected %0h got %0h", $time,
             $sampled(exp_cap_a_i), $sampled(debug_i.word_1));
      fail_cnt++;
    end

  a_cap_b: assert property (@(posedge clk) disable iff (!rst_n)
    hit_b |=> debug_i.word_2 == 32'(exp_cap_b_i))
    else begin
      $error("[FAIL] %0t debug_o.word_2 expected %0h got %0h", $time,
             $sampled(exp_cap_b_i), $sampled(debug_i.word_2));
      fail_cnt++;
    end

  a_keep_a: assert property (@(posedge clk) disable iff (!rst_n)
    !hit_a |=> $stable(debug_i.word_1))
    else begin
      $error("debug_o.word_1 changed without a watch hit on address A");
      fail_cnt++;
    end

  a_keep_b: assert property (@(posedge clk) disable iff (!rst_n)
    !hit_b |=> $stable(debug_i.word_2))
    else begin
      $error("debug_o.word_2 changed without a watch hit on address B");
      fail_cnt++;
    end

endmodule

// File: verif/gat_layer_tb.sv
`timescale 1ns/1ps
`include "gat_cfg.svh"

module gat_layer_tb;
  import gat_data_pkg::*;
  import gat_dbg_pkg::*;

  localparam int N            = `GAT_NUM_LANES;
  localparam int NUM_COLS     = 1 << `GAT_COL_W;
  localparam int RDY_TIMEOUT  = 100;
  localparam int DONE_TIMEOUT = 400;

  logic                        clk;
  logic                        rst_n;
  logic                        nz_vld_i;
  nonzero_t                    nz_i;
  node_idx_t                   node_idx_i;
  logic                        batch_last_i;
  logic                        wgt_we_i;
  logic [`GAT_COL_W-1:0]       wgt_col_i;
  wh_vec_t                     wgt_row_i;
  wh_vec_t                     attn_i;
  logic [`GAT_FEAT_ADDR_W-1:0] feat_base_i;
  logic                        spmm_rdy_o;
  logic                        aggr_vld_o;
  feat_wr_t                    feat_wr_o;
  debug_words_t                debug_o;

  // reference model, read by the bound checker
  logic [31:0]                  lfsr_q;
  wh_vec_t                      wgt_model [NUM_COLS];
  wh_vec_t                      attn_model;
  logic [N-1:0][`GAT_SUM_W-1:0] exp_sum;
  logic [`GAT_DENOM_W-1:0]      exp_denom;
  logic [`GAT_FEAT_ADDR_W-1:0]  exp_base;
  lane_t                        exp_cap_a;
  lane_t                        exp_cap_b;
  int                           nodes_sent;

  gat_layer_top gat_layer_top_inst (.*);

  bind gat_layer_top gat_layer_asserts gat_layer_asserts_inst (
    .clk, .rst_n, .nz_vld_i, .nz_i,
    .spmm_rdy_i  (spmm_rdy_o),
    .spmm_vld_i  (spmm_vld),
    .wh_addr_i   (spmm_rec.idx),
    .aggr_vld_i  (aggr_vld_o),
    .feat_wr_i   (feat_wr_o),
    .debug_i     (debug_o),
    .exp_sum_i   (gat_layer_tb.exp_sum),
    .exp_denom_i (gat_layer_tb.exp_denom),
    .exp_base_i  (gat_layer_tb.exp_base),
    .exp_cap_a_i (gat_layer_tb.exp_cap_a),
    .exp_cap_b_i (gat_layer_tb.exp_cap_b)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopping on first error");
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] draw(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < nbits; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic void model_node(input node_idx_t idx, input wh_vec_t wh);
    logic signed [`GAT_SCORE_W-1:0] score;
    logic signed [`GAT_SCORE_W-1:0] shifted;
    int                             expo;
    int                             wgt;
    int                             lane_v;
    int                             term;
    score = '0;
    for (int l = 0; l < N; l++) begin
      score = score + $signed(wh[l]) * $signed(attn_model[l]);
    end
    shifted = score >>> `GAT_SCORE_SHIFT;
    expo    = (shifted < 0) ? 0 : (shifted > 15) ? 15 : int'(shifted);
    wgt     = 1 << expo;
    for (int l = 0; l < N; l++) begin
      lane_v     = $signed(wh[l]);
      term       = wgt * lane_v;
      exp_sum[l] = exp_sum[l] + term; // wraps at 32 bits
    end
    exp_denom = exp_denom + wgt;
    if (idx == `GAT_WATCH_ADDR_A) exp_cap_a = wh[`GAT_WATCH_LANE];
    if (idx == `GAT_WATCH_ADDR_B) exp_cap_b = wh[`GAT_WATCH_LANE];
  endfunction

  task automatic check_word(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else abort_run($sformatf(
      "[FAIL] %0t %s expected %0h got %0h", $time, name, expected, actual));
  endtask

  task automatic wait_spmm_ready();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!spmm_rdy_o) begin
      cycles++;
      if (cycles > RDY_TIMEOUT) abort_run("timeout, spmm_rdy_o never came back high");
      @(negedge clk);
    end
  endtask

  task automatic wait_aggr_done();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!aggr_vld_o) begin
      cycles++;
      if (cycles > DONE_TIMEOUT) abort_run("timeout, aggr_vld_o never pulsed after a batch");
      @(negedge clk);
    end
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic load_weights();
    wh_vec_t row;
    for (int c = 0; c < NUM_COLS; c++) begin
      for (int l = 0; l < N; l++) row[l] = draw(`GAT_DATA_W);
      wgt_model[c] = row;
      @(posedge clk);
      wgt_we_i  <= 1'b1;
      wgt_col_i <= c[`GAT_COL_W-1:0];
      wgt_row_i <= row;
    end
    for (int l = 0; l < N; l++) attn_model[l] = lane_t'($signed(4'(draw(4)))); // -8..7
    @(posedge clk);
    wgt_we_i <= 1'b0;
    attn_i   <= attn_model;
  endtask

  task automatic send_node(input node_idx_t idx, input logic last);
    int                        n;
    wh_vec_t                   wh;
    logic [`GAT_COL_W-1:0]     col;
    lane_t                     val;
    logic [2*`GAT_DATA_W-1:0]  p;
    n  = 1 + draw(2);
    wh = '0;
    wait_spmm_ready();
    for (int k = 0; k < n; k++) begin
      col = draw(`GAT_COL_W);
      val = draw(`GAT_DATA_W);
      @(posedge clk);
      nz_vld_i     <= 1'b1;
      nz_i         <= '{value: val, col: col, last_nz: (k == n - 1)};
      node_idx_i   <= idx;
      batch_last_i <= last;
      for (int l = 0; l < N; l++) begin
        p     = val * wgt_model[col][l];
        wh[l] = wh[l] + p[`GAT_DATA_W-1:0];
      end
    end
    @(posedge clk);
    nz_vld_i <= 1'b0;
    model_node(idx, wh);
    nodes_sent++;
  endtask

  task automatic run_batch(input node_idx_t first_idx, input int n_nodes,
                           input logic [`GAT_FEAT_ADDR_W-1:0] base);
    exp_sum   = '0;
    exp_denom = '0;
    exp_base  = base;
    @(posedge clk);
    feat_base_i <= base;
    for (int i = 0; i < n_nodes; i++) begin
      send_node(node_idx_t'(first_idx + i), i == n_nodes - 1);
    end
    wait_aggr_done();
  endtask

  always @(negedge clk) begin
    if (gat_layer_top_inst.gat_layer_asserts_inst.fail_cnt != 0) begin
      abort_run("a bound assertion failed, see the error above");
    end
  end

  initial begin
    rst_n        = 1'b0;
    nz_vld_i     = 1'b0;
    nz_i         = '0;
    node_idx_i   = '0;
    batch_last_i = 1'b0;
    wgt_we_i     = 1'b0;
    wgt_col_i    = '0;
    wgt_row_i    = '0;
    attn_i       = '0;
    feat_base_i  = '0;
    lfsr_q       = 32'h4a50_7b7a;
    exp_sum      = '0;
    exp_denom    = '0;
    exp_base     = '0;
    exp_cap_a    = '0;
    exp_cap_b    = '0;
    nodes_sent   = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    load_weights();
    run_batch(14'd3, 1, 16'h0100);
    check_word("debug_o.word_0[8]", 32'd0, 32'(debug_o.word_0[8]));
    run_batch(14'd10, 3, `GAT_FEAT_ADDR_W'(`GAT_FEAT_LIMIT - N - 1)); // ends just under limit
    check_word("debug_o.word_0[8]", 32'd0, 32'(debug_o.word_0[8]));
    run_batch(14'd20, 5, `GAT_FEAT_ADDR_W'(`GAT_FEAT_LIMIT)); // at the range limit
    @(negedge clk);
    check_word("debug_o.word_0[7:0]", 32'hff, 32'(debug_o.word_0[7:0]));
    check_word("debug_o.word_0[8]", 32'd1, 32'(debug_o.word_0[8]));
    check_word("debug_o.word_0[31:16]", 32'(nodes_sent), 32'(debug_o.word_0[31:16]));
    check_word("debug_o.word_1", 32'(exp_cap_a), debug_o.word_1);
    check_word("debug_o.word_2", 32'(exp_cap_b), debug_o.word_2);
    if (gat_layer_top_inst.gat_layer_asserts_inst.fail_cnt == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      abort_run("a bound assertion failed near the end of the run");
    end
  end

endmodule

// File: gat_layer.f
+incdir+src
src/gat_data_pkg.sv
src/gat_dbg_pkg.sv
src/spmm_engine.sv
src/dmvm_engine.sv
src/softmax_unit.sv
src/aggr_engine.sv
src/debug_monitor.sv
src/gat_layer_top.sv
verif/gat_layer_asserts.sv
verif/gat_layer_tb.sv

// File: Bender.yml
package:
  name: gat_layer

export_include_dirs:
  - src

sources:
  - files:
      - src/gat_data_pkg.sv
      - src/gat_dbg_pkg.sv
      - src/spmm_engine.sv
      - src/dmvm_engine.sv
      - src/softmax_unit.sv
      - src/aggr_engine.sv
      - src/debug_monitor.sv
      - src/gat_layer_top.sv
  - target: test
    files:
      - verif/gat_layer_asserts.sv
      - verif/gat_layer_tb.sv
